// File: hni_data_buffer.f
rtl/hni_dbf_pkg.sv
rtl/dbf_entry_ctrl.sv
rtl/dbf_line_store.sv
rtl/dbf_axi_w_sender.sv
rtl/dbf_txdat_packer.sv
rtl/hni_data_buffer.sv
sim/hni_data_buffer_properties.sv
sim/tb_hni_data_buffer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hni_data_buffer \
    -f hni_data_buffer.f

out=$(./obj_dir/Vtb_hni_data_buffer 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed"

// File: sim/tb_hni_data_buffer.sv
`timescale 1ns/1ps

module tb_hni_data_buffer;
    import hni_dbf_pkg::*;

    localparam int                  num_entries = 4;
    localparam int                  idx_w       = 2;
    localparam logic [NODEID_W-1:0] node_id     = 7'h12;
    localparam int                  wait_limit  = 60;

    logic                  clk;
    logic                  rst;
    alloc_t                alloc;
    logic                  rxdat_valid;
    dat_flit_t             rxdat_flit;
    logic                  retire_valid;
    logic [idx_w-1:0]      retire_idx;
    logic                  wdat_en;
    logic [idx_w-1:0]      wdat_idx;
    logic                  rdat_en;
    logic [idx_w-1:0]      rdat_idx;
    txdat_cmd_t            txdat_cmd;
    logic [AXID_W-1:0]     rid;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wlast;
    logic                  wvalid;
    logic                  wready;
    logic                  w_done;
    rbeat_t                rbeat;
    logic                  txdat_valid;
    dat_flit_t             txdat_flit;

    // reference model with one line per entry
    logic [127:0] m_line  [num_entries];
    logic [15:0]  m_be    [num_entries];
    logic [1:0]   m_chunk [num_entries];
    logic [1:0]   m_rresp [num_entries];

    logic [31:0] lfsr;
    int          errors;
    int          tests;
    int          failed_tests;

    hni_data_buffer #(.num_entries(num_entries), .node_id(node_id)) uut (.*);

    bind hni_data_buffer hni_dbf_properties u_props (
        .clk         (clk),
        .rst         (rst),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .rready      (rready),
        .rbeat       (rbeat),
        .txdat_valid (txdat_valid),
        .txdat_flit  (txdat_flit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int last_beat(input logic [1:0] chunk, input logic [7:0] len);
        int s;
        s = int'(chunk) + int'(len);
        return (s > LINE_BEATS - 1) ? LINE_BEATS - 1 : s;
    endfunction

    task automatic check_val(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_start);
        end
    endtask

    task automatic retire_entry(input int e);
        @(negedge clk);
        retire_valid = 1'b1;
        retire_idx   = idx_w'(e);
        @(negedge clk);
        retire_valid = 1'b0;
        m_line[e]  = '0;
        m_be[e]    = '0;
        m_chunk[e] = '0;
        m_rresp[e] = '0;
    endtask

    task automatic alloc_entry(input int e, input logic [AXID_W-1:0] axid, input logic wr,
                               input logic [1:0] chunk, input logic [7:0] len);
        @(negedge clk);
        alloc       = '0;
        alloc.en    = 1'b1;
        alloc.idx   = MAX_IDX_W'(e);
        alloc.axid  = axid;
        alloc.wr    = wr;
        alloc.chunk = chunk;
        alloc.axlen = len;
        @(negedge clk);
        alloc      = '0;
        m_chunk[e] = chunk;
        m_rresp[e] = '0;
    endtask

    task automatic send_flit(input int e, input int half, input logic [63:0] data,
                             input logic [7:0] be);
        @(negedge clk);
        rxdat_flit        = '0;
        rxdat_flit.txnid  = {6'(rand_bits(6)), idx_w'(e)};   // entry in the low bits
        rxdat_flit.dataid = half ? 2'b10 : 2'b00;
        rxdat_flit.be     = be;
        rxdat_flit.data   = data;
        rxdat_valid       = 1'b1;
        @(negedge clk);
        rxdat_valid = 1'b0;
        m_line[e][half*64 +: 64] = data;
        m_be[e][half*8 +: 8]     = m_be[e][half*8 +: 8] | be;
    endtask

    task automatic run_write_burst(input int e, input logic [1:0] chunk, input logic [7:0] len);
        int beat;
        int last;
        int cycles;
        int done_cnt;
        last     = last_beat(chunk, len);
        beat     = int'(chunk);
        cycles   = 0;
        done_cnt = 0;
        @(negedge clk);
        wdat_en  = 1'b1;
        wdat_idx = idx_w'(e);
        @(negedge clk);
        wdat_en = 1'b0;
        wready  = (rand_bits(2) != 0);
        while (beat <= last && cycles < wait_limit) begin
            #2;   // inputs and state settled
            if (w_done) begin
                done_cnt++;
            end
            check_val("wvalid", wvalid, 1'b1);
            if (wvalid) begin
                check_val("wdata", wdata, m_line[e][beat*32 +: 32]);
                check_val("wstrb", wstrb, m_be[e][beat*4 +: 4]);
                check_val("wlast", wlast, beat == last);
                check_val("w_done", w_done, wready && beat == last);
                if (wready) begin
                    beat++;
                end
            end
            @(negedge clk);
            wready = (rand_bits(2) != 0);
            cycles++;
        end
        if (beat <= last) begin
            report_timeout("last W beat");
        end else begin
            #2;
            check_val("w_done count", done_cnt, 1);
            check_val("wvalid after burst", wvalid, 1'b0);
        end
        wready = 1'b0;
    endtask

    task automatic run_read_burst(input int e, input logic [AXID_W-1:0] axid,
                                  input logic [1:0] chunk, input logic [7:0] len,
                                  input logic [1:0] resp);
        int beat;
        int last;
        int cycles;
        last   = last_beat(chunk, len);
        beat   = int'(chunk);
        cycles = 0;
        @(negedge clk);
        rdat_en  = 1'b1;
        rdat_idx = idx_w'(e);
        @(negedge clk);
        rdat_en = 1'b0;
        #2;
        while (!rready && cycles < wait_limit) begin
            @(negedge clk);
            #2;
            cycles++;
        end
        if (!rready) begin
            report_timeout("rready");
            return;
        end
        cycles = 0;
        while (beat <= last && cycles < wait_limit) begin
            @(negedge clk);
            rvalid = (rand_bits(2) != 0);
            rid    = axid;
            rdata  = rand_bits(32);
            rresp  = resp;
            rlast  = (beat == last);
            #2;
            check_val("rready during burst", rready, 1'b1);
            check_val("rbeat.valid", rbeat.valid, rvalid);
            if (rvalid) begin
                check_val("rbeat.idx", rbeat.idx, MAX_IDX_W'(e));
                check_val("rbeat.mask", rbeat.mask, 4'(1) << beat);
                m_line[e][beat*32 +: 32] = m_line[e][beat*32 +: 32] | rdata;
                beat++;
            end
            cycles++;
        end
        @(negedge clk);
        rvalid = 1'b0;
        rlast  = 1'b0;
        if (beat <= last) begin
            report_timeout("rlast beat");
        end else begin
            m_rresp[e] = resp;
            #2;
            check_val("rready after rlast", rready, 1'b0);
        end
    endtask

    task automatic check_txdat(input int e, input int half, input logic [3:0] opc,
                               input logic [1:0] resperr);
        logic [1:0] exp_err;
        @(negedge clk);
        txdat_cmd         = '0;
        txdat_cmd.en      = 1'b1;
        txdat_cmd.tgtid   = 7'(rand_bits(7));
        txdat_cmd.txnid   = 8'(rand_bits(8));
        txdat_cmd.opcode  = opc;
        txdat_cmd.resp    = 3'(rand_bits(3));
        txdat_cmd.resperr = resperr;
        txdat_cmd.dbid    = {6'(rand_bits(6)), idx_w'(e)};
        txdat_cmd.dataid  = half ? 2'b10 : 2'b00;
        exp_err = (m_rresp[e] == RESP_SLVERR) ? RESP_SLVERR : resperr;
        #2;
        check_val("txdat_valid", txdat_valid, 1'b1);
        check_val("txdat data", txdat_flit.data, m_line[e][half*64 +: 64]);
        check_val("txdat be", txdat_flit.be, 8'hff);
        check_val("txdat resperr", txdat_flit.resperr, exp_err);
        check_val("txdat srcid", txdat_flit.srcid, node_id);
        check_val("txdat homenid", txdat_flit.homenid, (opc == OP_COMPDATA) ? node_id : 7'h0);
        check_val("txdat ccid", txdat_flit.ccid, m_chunk[e]);
        check_val("txdat tgtid", txdat_flit.tgtid, txdat_cmd.tgtid);
        check_val("txdat txnid", txdat_flit.txnid, txdat_cmd.txnid);
        check_val("txdat dbid", txdat_flit.dbid, txdat_cmd.dbid);
        check_val("txdat opcode", txdat_flit.opcode, opc);
        check_val("txdat resp", txdat_flit.resp, txdat_cmd.resp);
        check_val("txdat dataid", txdat_flit.dataid, txdat_cmd.dataid);
        @(negedge clk);
        txdat_cmd = '0;
        #2;
        check_val("txdat_valid idle", txdat_valid, 1'b0);
    endtask

    initial begin
        int                e;
        int                err_start;
        logic [1:0]        chunk;
        logic [7:0]        len;
        logic [1:0]        resp;
        logic [63:0]       fdata;
        logic [AXID_W-1:0] axid;

        rst          = 1'b1;
        alloc        = '0;
        rxdat_valid  = 1'b0;
        rxdat_flit   = '0;
        retire_valid = 1'b0;
        retire_idx   = '0;
        wdat_en      = 1'b0;
        wdat_idx     = '0;
        rdat_en      = 1'b0;
        rdat_idx     = '0;
        txdat_cmd    = '0;
        rid          = '0;
        rdata        = '0;
        rresp        = '0;
        rlast        = 1'b0;
        rvalid       = 1'b0;
        wready       = 1'b0;
        lfsr         = 32'he443_c674;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        e            = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        err_start = errors;
        #2;
        check_val("rready", rready, 1'b0);
        check_val("wvalid", wvalid, 1'b0);
        check_val("wlast", wlast, 1'b0);
        check_val("w_done", w_done, 1'b0);
        check_val("rbeat.valid", rbeat.valid, 1'b0);
        check_val("txdat_valid", txdat_valid, 1'b0);
        end_test("reset state", err_start);

        for (int n = 0; n < 6; n++) begin
            err_start = errors;
            e     = int'(rand_bits(2));
            chunk = 2'(rand_bits(2));
            len   = 8'(rand_bits(3));   // lengths past beat 3 get capped
            retire_entry(e);
            alloc_entry(e, 4'(rand_bits(4)), 1'b1, chunk, len);
            fdata[63:32] = rand_bits(32);
            fdata[31:0]  = rand_bits(32);
            send_flit(e, 0, fdata, 8'(rand_bits(8)));
            fdata[63:32] = rand_bits(32);
            fdata[31:0]  = rand_bits(32);
            send_flit(e, 1, fdata, 8'(rand_bits(8)));
            run_write_burst(e, chunk, len);
            check_txdat(e, 0, OP_COMPDATA, 2'b00);
            check_txdat(e, 1, 4'(rand_bits(4)), 2'(rand_bits(2)));
            end_test("write path", err_start);
        end

        for (int n = 0; n < 6; n++) begin
            err_start = errors;
            e     = int'(rand_bits(2));
            chunk = 2'(rand_bits(2));
            len   = 8'(rand_bits(3));
            axid  = 4'(rand_bits(4));
            resp  = n[0] ? RESP_SLVERR : 2'b00;
            retire_entry(e);
            alloc_entry(e, axid, 1'b0, chunk, len);
            run_read_burst(e, axid, chunk, len, resp);
            check_txdat(e, 0, OP_COMPDATA, 2'(rand_bits(2)));
            check_txdat(e, 1, 4'(rand_bits(4)), 2'(rand_bits(2)));
            end_test(n[0] ? "read path slverr" : "read path okay", err_start);
        end

        err_start = errors;
        retire_entry(e);
        check_txdat(e, 0, OP_COMPDATA, 2'b00);
        check_txdat(e, 1, 4'(rand_bits(4)), 2'b00);
        end_test("retirement", err_start);

        $display("summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sim/hni_data_buffer_properties.sv
`timescale 1ns/1ps

module hni_dbf_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   wlast,
    input logic                   wvalid,
    input logic                   rready,
    input hni_dbf_pkg::rbeat_t    rbeat,
    input logic                   txdat_valid,
    input hni_dbf_pkg::dat_flit_t txdat_flit
);
    import hni_dbf_pkg::*;

    a_wlast_valid: assert property (@(posedge clk) disable iff (rst) wlast |-> wvalid)
        else $error("wlast high while wvalid is low");

    a_rbeat_onehot: assert property (@(posedge clk) disable iff (rst)
        rbeat.valid |-> $onehot(rbeat.mask))
        else $error("rbeat mask is not one-hot");

    a_txdat_be: assert property (@(posedge clk) disable iff (rst)
        txdat_valid |-> (txdat_flit.be == {CHI_BE_W{1'b1}}))
        else $error("outgoing flit byte enables not all set");

    // first edge out of reset
    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> (!rready && !wvalid))
        else $error("rready or wvalid high right after reset");

endmodule

// File: rtl/hni_data_buffer.sv
`timescale 1ns/1ps

module hni_data_buffer #(
    parameter int                               num_entries = 4,
    parameter logic [hni_dbf_pkg::NODEID_W-1:0] node_id     = 7'h12
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  hni_dbf_pkg::alloc_t                   alloc,
    input  logic                                  rxdat_valid,
    input  hni_dbf_pkg::dat_flit_t                rxdat_flit,
    input  logic                                  retire_valid,
    input  logic [$clog2(num_entries)-1:0]        retire_idx,
    input  logic                                  wdat_en,
    input  logic [$clog2(num_entries)-1:0]        wdat_idx,
    input  logic                                  rdat_en,
    input  logic [$clog2(num_entries)-1:0]        rdat_idx,
    input  hni_dbf_pkg::txdat_cmd_t               txdat_cmd,
    input  logic [hni_dbf_pkg::AXID_W-1:0]        rid,
    input  logic [hni_dbf_pkg::AXI_DATA_W-1:0]    rdata,
    input  logic [1:0]                            rresp,
    input  logic                                  rlast,
    input  logic                                  rvalid,
    output logic                                  rready,
    output logic [hni_dbf_pkg::AXI_DATA_W-1:0]    wdata,
    output logic [hni_dbf_pkg::AXI_STRB_W-1:0]    wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  logic                                  wready,
    output logic                                  w_done,
    output hni_dbf_pkg::rbeat_t                   rbeat,
    output logic                                  txdat_valid,
    output hni_dbf_pkg::dat_flit_t                txdat_flit
);
    import hni_dbf_pkg::*;

    logic [num_entries-1:0] wr_entries;
    logic [1:0]             entry_ccid [num_entries];
    logic [1:0]             entry_rresp [num_entries];
    beat_mask_t             start_mask;
    beat_mask_t             last_mask;
    line_t                  lines [num_entries];
    line_be_t               line_be [num_entries];

    dbf_entry_ctrl #(.num_entries(num_entries)) u_entry_ctrl (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .retire_valid (retire_valid),
        .retire_idx   (retire_idx),
        .rdat_en      (rdat_en),
        .rdat_idx     (rdat_idx),
        .rid          (rid),
        .rresp        (rresp),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .rbeat        (rbeat),
        .wr_entries   (wr_entries),
        .entry_ccid   (entry_ccid),
        .entry_rresp  (entry_rresp),
        .start_mask   (start_mask),
        .last_mask    (last_mask)
    );

    dbf_line_store #(.num_entries(num_entries)) u_line_store (
        .clk          (clk),
        .rst          (rst),
        .rxdat_valid  (rxdat_valid),
        .rxdat_flit   (rxdat_flit),
        .wr_entries   (wr_entries),
        .rbeat        (rbeat),
        .rdata        (rdata),
        .retire_valid (retire_valid),
        .retire_idx   (retire_idx),
        .lines        (lines),
        .line_be      (line_be)
    );

    dbf_axi_w_sender #(.num_entries(num_entries)) u_w_sender (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .start_mask (start_mask),
        .last_mask  (last_mask),
        .wdat_en    (wdat_en),
        .wdat_idx   (wdat_idx),
        .lines      (lines),
        .line_be    (line_be),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .w_done     (w_done)
    );

    dbf_txdat_packer #(
        .num_entries (num_entries),
        .node_id     (node_id)
    ) u_packer (
        .txdat_cmd   (txdat_cmd),
        .lines       (lines),
        .entry_ccid  (entry_ccid),
        .entry_rresp (entry_rresp),
        .txdat_valid (txdat_valid),
        .txdat_flit  (txdat_flit)
    );

endmodule

// File: rtl/dbf_txdat_packer.sv
`timescale 1ns/1ps

module dbf_txdat_packer #(
    parameter int                               num_entries = 4,
    parameter logic [hni_dbf_pkg::NODEID_W-1:0] node_id     = 7'h12
) (
    input  hni_dbf_pkg::txdat_cmd_t    txdat_cmd,
    input  hni_dbf_pkg::line_t         lines [num_entries],
    input  logic [1:0]                 entry_ccid [num_entries],
    input  logic [1:0]                 entry_rresp [num_entries],
    output logic                       txdat_valid,
    output hni_dbf_pkg::dat_flit_t     txdat_flit
);
    import hni_dbf_pkg::*;

    localparam int idx_w = $clog2(num_entries);

    logic [idx_w-1:0] idx;
    logic             half;

    assign idx  = txdat_cmd.dbid[idx_w-1:0];
    assign half = txdat_cmd.dataid[1];

    assign txdat_valid = txdat_cmd.en;

    always_comb begin
        txdat_flit.tgtid   = txdat_cmd.tgtid;
        txdat_flit.srcid   = node_id;
        txdat_flit.homenid = (txdat_cmd.opcode == OP_COMPDATA) ? node_id : '0;
        txdat_flit.txnid   = txdat_cmd.txnid;
        txdat_flit.opcode  = txdat_cmd.opcode;
        // slave error overrides what the tracker asked for
        txdat_flit.resperr = (entry_rresp[idx] == RESP_SLVERR) ? RESP_SLVERR
                                                               : txdat_cmd.resperr;
        txdat_flit.resp    = txdat_cmd.resp;
        txdat_flit.dbid    = txdat_cmd.dbid;
        txdat_flit.ccid    = entry_ccid[idx];
        txdat_flit.dataid  = txdat_cmd.dataid;
        txdat_flit.be      = '1;
        txdat_flit.data    = lines[idx].chi[half];
    end

endmodule

// File: rtl/dbf_axi_w_sender.sv
`timescale 1ns/1ps

module dbf_axi_w_sender #(
    parameter int num_entries = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  hni_dbf_pkg::alloc_t                   alloc,
    input  hni_dbf_pkg::beat_mask_t               start_mask,
    input  hni_dbf_pkg::beat_mask_t               last_mask,
    input  logic                                  wdat_en,
    input  logic [$clog2(num_entries)-1:0]        wdat_idx,
    input  hni_dbf_pkg::line_t                    lines [num_entries],
    input  hni_dbf_pkg::line_be_t                 line_be [num_entries],
    input  logic                                  wready,
    output logic [hni_dbf_pkg::AXI_DATA_W-1:0]    wdata,
    output logic [hni_dbf_pkg::AXI_STRB_W-1:0]    wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    output logic                                  w_done
);
    import hni_dbf_pkg::*;

    localparam int idx_w = $clog2(num_entries);

    logic [num_entries-1:0] armed_q;
    beat_mask_t             cd_q [num_entries];
    beat_mask_t             wl_q [num_entries];
    logic [idx_w-1:0]       sel;
    beat_mask_t             cur_cd;
    beat_mask_t             cur_wl;

    // highest armed index wins
    always_comb begin
        sel = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (armed_q[i]) begin
                sel = idx_w'(i);
            end
        end
    end

    assign cur_cd = cd_q[sel];
    assign cur_wl = wl_q[sel];
    assign wvalid = |armed_q;
    assign wlast  = wvalid && (cur_cd == cur_wl);
    assign w_done = wvalid && wready && wlast;

    always_comb begin
        wdata = '0;
        wstrb = '0;
        for (int k = 0; k < LINE_BEATS; k++) begin
            if (cur_cd[k]) begin
                wdata = lines[sel].axi[k];
                wstrb = line_be[sel].axi[k];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed_q <= '0;
            cd_q    <= '{default: '0};
            wl_q    <= '{default: '0};
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (alloc.en && alloc.wr && alloc.idx[idx_w-1:0] == idx_w'(i)) begin
                    cd_q[i] <= start_mask;
                    wl_q[i] <= last_mask;
                end else if (wvalid && wready && sel == idx_w'(i)) begin
                    if (wlast) begin
                        cd_q[i] <= '0;
                        wl_q[i] <= '0;
                    end else begin
                        cd_q[i] <= cd_q[i] << 1;
                    end
                end

                if (wdat_en && wdat_idx == idx_w'(i)) begin
                    armed_q[i] <= 1'b1;
                end else if (w_done && sel == idx_w'(i)) begin
                    armed_q[i] <= 1'b0;   // burst finished
                end
            end
        end
    end

endmodule

// File: rtl/dbf_line_store.sv
`timescale 1ns/1ps

module dbf_line_store #(
    parameter int num_entries = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rxdat_valid,
    input  hni_dbf_pkg::dat_flit_t                rxdat_flit,
    input  logic [num_entries-1:0]                wr_entries,
    input  hni_dbf_pkg::rbeat_t                   rbeat,
    input  logic [hni_dbf_pkg::AXI_DATA_W-1:0]    rdata,
    input  logic                                  retire_valid,
    input  logic [$clog2(num_entries)-1:0]        retire_idx,
    output hni_dbf_pkg::line_t                    lines [num_entries],
    output hni_dbf_pkg::line_be_t                 line_be [num_entries]
);
    import hni_dbf_pkg::*;

    localparam int idx_w = $clog2(num_entries);

    logic [idx_w-1:0] flit_idx;
    logic             flit_half;

    assign flit_idx  = rxdat_flit.txnid[idx_w-1:0];
    assign flit_half = rxdat_flit.dataid[1];

    // R beats merge into the line by OR
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lines   <= '{default: '0};
            line_be <= '{default: '0};
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (retire_valid && retire_idx == idx_w'(i)) begin
                    lines[i]   <= '0;
                    line_be[i] <= '0;
                end else if (rxdat_valid && wr_entries[i] && flit_idx == idx_w'(i)) begin
                    lines[i].chi[flit_half]   <= rxdat_flit.data;
                    line_be[i].chi[flit_half] <= line_be[i].chi[flit_half] | rxdat_flit.be;
                end else if (rbeat.valid && rbeat.idx[idx_w-1:0] == idx_w'(i)) begin
                    for (int k = 0; k < LINE_BEATS; k++) begin
                        if (rbeat.mask[k]) begin
                            lines[i].axi[k] <= lines[i].axi[k] | rdata;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: rtl/dbf_entry_ctrl.sv
`timescale 1ns/1ps

module dbf_entry_ctrl #(
    parameter int num_entries = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  hni_dbf_pkg::alloc_t               alloc,
    input  logic                              retire_valid,
    input  logic [$clog2(num_entries)-1:0]    retire_idx,
    input  logic                              rdat_en,
    input  logic [$clog2(num_entries)-1:0]    rdat_idx,
    input  logic [hni_dbf_pkg::AXID_W-1:0]    rid,
    input  logic [1:0]                        rresp,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready,
    output hni_dbf_pkg::rbeat_t               rbeat,
    output logic [num_entries-1:0]            wr_entries,
    output logic [1:0]                        entry_ccid [num_entries],
    output logic [1:0]                        entry_rresp [num_entries],
    output hni_dbf_pkg::beat_mask_t           start_mask,
    output hni_dbf_pkg::beat_mask_t           last_mask
);
    import hni_dbf_pkg::*;

    localparam int idx_w = $clog2(num_entries);

    logic [AXID_W-1:0]      axid_q [num_entries];
    logic [num_entries-1:0] armed_q;
    beat_mask_t             rd_cd_q [num_entries];
    logic [num_entries-1:0] hit;
    logic [AXLEN_W:0]       last_sum;
    logic [1:0]             last_beat;

    // device rule starts at the chunk and stops at chunk + len capped at beat 3
    always_comb begin
        last_sum   = (AXLEN_W+1)'(alloc.chunk) + (AXLEN_W+1)'(alloc.axlen);
        last_beat  = (last_sum > (AXLEN_W+1)'(LINE_BEATS-1)) ? 2'(LINE_BEATS-1) : last_sum[1:0];
        start_mask = beat_mask_t'(1) << alloc.chunk;
        last_mask  = beat_mask_t'(1) << last_beat;
    end

    assign rready = |armed_q;

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            hit[i] = rvalid && rready && armed_q[i] && (rid == axid_q[i]);
        end
    end

    // one armed read per axid, so at most one hit
    always_comb begin
        rbeat = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (hit[i]) begin
                rbeat.valid = 1'b1;
                rbeat.idx   = MAX_IDX_W'(i);
                rbeat.mask  = rd_cd_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_entries; i++) begin
            if (alloc.en && alloc.idx[idx_w-1:0] == idx_w'(i)) begin
                axid_q[i]     <= alloc.axid;
                entry_ccid[i] <= alloc.chunk;
            end else if (retire_valid && retire_idx == idx_w'(i)) begin
                axid_q[i]     <= '0;
                entry_ccid[i] <= '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_entries  <= '0;
            armed_q     <= '0;
            rd_cd_q     <= '{default: '0};
            entry_rresp <= '{default: '0};
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (alloc.en && alloc.idx[idx_w-1:0] == idx_w'(i)) begin
                    wr_entries[i]  <= alloc.wr;
                    entry_rresp[i] <= '0;
                    rd_cd_q[i]     <= alloc.wr ? '0 : start_mask;
                end else if (retire_valid && retire_idx == idx_w'(i)) begin
                    wr_entries[i]  <= 1'b0;
                    entry_rresp[i] <= '0;
                    rd_cd_q[i]     <= '0;
                end else if (hit[i]) begin
                    entry_rresp[i] <= rresp;
                    if (rlast) begin
                        rd_cd_q[i] <= '0;
                    end else begin
                        rd_cd_q[i] <= rd_cd_q[i] << 1;   // next slot
                    end
                end

                if (rdat_en && rdat_idx == idx_w'(i)) begin
                    armed_q[i] <= 1'b1;
                end else if ((hit[i] && rlast) || (retire_valid && retire_idx == idx_w'(i))) begin
                    armed_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/hni_dbf_pkg.sv
package hni_dbf_pkg;

    localparam int CHI_DATA_W = 64;
    localparam int CHI_BE_W   = 8;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = 4;
    localparam int LINE_BEATS = 4;
    localparam int AXID_W     = 4;
    localparam int TXNID_W    = 8;
    localparam int NODEID_W   = 7;
    localparam int AXLEN_W    = 8;
    localparam int OPCODE_W   = 4;
    localparam int MAX_IDX_W  = 3;     // room for up to 8 entries

    localparam logic [1:0]          RESP_SLVERR = 2'b10;
    localparam logic [OPCODE_W-1:0] OP_COMPDATA = 4'h4;

    typedef logic [LINE_BEATS-1:0] beat_mask_t;

    typedef struct packed {
        logic [NODEID_W-1:0]   tgtid;
        logic [NODEID_W-1:0]   srcid;
        logic [NODEID_W-1:0]   homenid;
        logic [TXNID_W-1:0]    txnid;
        logic [OPCODE_W-1:0]   opcode;
        logic [1:0]            resperr;
        logic [2:0]            resp;
        logic [TXNID_W-1:0]    dbid;
        logic [1:0]            ccid;
        logic [1:0]            dataid;
        logic [CHI_BE_W-1:0]   be;
        logic [CHI_DATA_W-1:0] data;
    } dat_flit_t;

    typedef struct packed {
        logic                 en;
        logic [MAX_IDX_W-1:0] idx;
        logic [AXID_W-1:0]    axid;
        logic                 wr;
        logic [1:0]           chunk;   // addr[5:4]
        logic [AXLEN_W-1:0]   axlen;
    } alloc_t;

    typedef struct packed {
        logic                en;
        logic [NODEID_W-1:0] tgtid;
        logic [TXNID_W-1:0]  txnid;
        logic [OPCODE_W-1:0] opcode;
        logic [2:0]          resp;
        logic [1:0]          resperr;
        logic [TXNID_W-1:0]  dbid;
        logic [1:0]          dataid;
    } txdat_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [MAX_IDX_W-1:0] idx;
        beat_mask_t           mask;
    } rbeat_t;

    // chi halves picked by dataid[1], axi beats by the one-hot mask
    typedef union packed {
        logic [1:0][CHI_DATA_W-1:0]            chi;
        logic [LINE_BEATS-1:0][AXI_DATA_W-1:0] axi;
    } line_t;

    typedef union packed {
        logic [1:0][CHI_BE_W-1:0]              chi;
        logic [LINE_BEATS-1:0][AXI_STRB_W-1:0] axi;
    } line_be_t;

endpackage
